//--- design/stlb_cfg_pkg.sv
/*
 * Geometry and width constants for the shared TLB.
 * Import this package before the type package; every RTL block and
 * the testbench take their sizes from here.
 */
package stlb_cfg_pkg;

	// Address and page size
	localparam int ADDR_W    = 32;
	localparam int PAGE_BITS = 14;
	localparam int VPN_W     = ADDR_W - PAGE_BITS;

	// Way and index geometry
	localparam int IDX_BITS    = 4;
	localparam int IDX_ENTRIES = 1 << IDX_BITS;
	localparam int NUM_WAYS    = 4;
	localparam int WAY_BITS    = 2;

	localparam int ASID_W = 8;
	// Generation zero is never the master value
	localparam int GEN_W  = 6;

	// Register port
	localparam int DATA_W = 32;

	// ====================
	// Reset mapping of the top pages
	// ====================
	localparam int ROM_WAY = NUM_WAYS - 1;
	localparam logic [VPN_W-1:0] ROM_VPN_BASE = {{(VPN_W-IDX_BITS){1'b1}}, {IDX_BITS{1'b0}}};
	localparam logic [2:0] ROM_RWX = 3'b111;

endpackage

//--- design/stlb_lookup.sv
/*
 * Lookup pipeline. Stage one indexes every way by the low VPN bits
 * and holds the request; stage two compares tags and registers the
 * response, two clocks after the request.
 */
module stlb_lookup (
	input  logic                                                 rst_i,
	input  logic                                                 clk_g,
	input  stlb_types_pkg::xlat_req_t                            xlat_req_i,
	input  logic [stlb_cfg_pkg::GEN_W-1:0]                       master_gen_i,
	output logic [stlb_cfg_pkg::IDX_BITS-1:0]                    b_addr_o,
	input  stlb_types_pkg::tlb_entry_t [stlb_cfg_pkg::NUM_WAYS-1:0] b_dout_i,
	output stlb_types_pkg::xlat_resp_t                           xlat_resp_o
);
	import stlb_cfg_pkg::*;
	import stlb_types_pkg::*;

	xlat_req_t           req_q;
	logic [VPN_W-1:0]    req_vpn;
	logic [NUM_WAYS-1:0] way_hit;
	xlat_resp_t          resp_d;

	// ====================
	// Stage 1
	// ====================
	assign b_addr_o = xlat_req_i.vadr[PAGE_BITS +: IDX_BITS];

	// Lines up with the RAM read
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			req_q <= '0;
		end else begin
			req_q <= xlat_req_i;
		end
	end

	// ====================
	// Stage 2
	// ====================
	assign req_vpn = req_q.vadr[ADDR_W-1:PAGE_BITS];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = (b_dout_i[w].gen == master_gen_i) &&
				b_dout_i[w].pte.valid &&
				((b_dout_i[w].tag.asid == req_q.asid) || b_dout_i[w].pte.glob) &&
				(b_dout_i[w].tag.vpn == req_vpn);
		end
	end

	// Lowest way wins if several match
	always_comb begin
		resp_d = '0;
		resp_d.valid = req_q.valid;
		resp_d.hit = req_q.valid & (|way_hit);
		resp_d.padr = req_q.vadr;
		resp_d.vadr = req_q.vadr;
		resp_d.asid = req_q.asid;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				resp_d.rwx = b_dout_i[w].pte.rwx;
				resp_d.padr = {b_dout_i[w].pte.ppn, req_q.vadr[PAGE_BITS-1:0]};
			end
		end
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			xlat_resp_o <= '0;
		end else begin
			xlat_resp_o <= resp_d;
		end
	end

endmodule

//--- design/stlb_maint.sv
/*
 * Maintenance side of the TLB: owns port A of every way.
 * After reset it fills ROM_WAY with identity pages, then serves write,
 * read-back and invalidate-all commands. Invalidate bumps the master
 * generation and sweeps every index, clearing entries of old generations.
 */
module stlb_maint (
	input  logic                                                 rst_i,
	input  logic                                                 clk_g,
	input  stlb_types_pkg::maint_cmd_t                           cmd_i,
	output logic                                                 rdy_o,
	output logic [stlb_cfg_pkg::GEN_W-1:0]                       master_gen_o,
	output stlb_types_pkg::tlb_entry_t                           rd_entry_o,
	output logic                                                 rd_done_o,
	output logic [stlb_cfg_pkg::IDX_BITS-1:0]                    a_addr_o,
	output logic [stlb_cfg_pkg::NUM_WAYS-1:0]                    a_we_o,
	output stlb_types_pkg::tlb_entry_t                           a_din_o,
	input  stlb_types_pkg::tlb_entry_t [stlb_cfg_pkg::NUM_WAYS-1:0] a_dout_i
);
	import stlb_cfg_pkg::*;
	import stlb_types_pkg::*;

	maint_state_e        state_q;
	logic [IDX_BITS-1:0] addr_q;
	logic [NUM_WAYS-1:0] we_q;
	logic [WAY_BITS-1:0] way_q;
	tlb_entry_t          din_q;
	tlb_entry_t          rom_din;
	logic [NUM_WAYS-1:0] stale;
	logic [GEN_W-1:0]    gen_next;
	logic                busy;
	logic                accept;

	// Pending write or read-back still in flight
	assign busy   = (|we_q) | rd_done_o;
	assign accept = (state_q == ST_RUN) && !busy;
	assign rdy_o  = accept && (cmd_i.op == CMD_NONE);

	// Master count skips zero on wrap
	assign gen_next = (master_gen_o == '1) ? GEN_W'(1) : master_gen_o + 1'b1;

	// Identity page for the current fill index
	always_comb begin
		rom_din = '0;
		rom_din.gen = master_gen_o;
		rom_din.tag.vpn = ROM_VPN_BASE | VPN_W'(addr_q);
		rom_din.pte.valid = 1'b1;
		rom_din.pte.glob = 1'b1;
		rom_din.pte.rwx = ROM_RWX;
		rom_din.pte.ppn = ROM_VPN_BASE | VPN_W'(addr_q);
	end

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			stale[w] = a_dout_i[w].gen != master_gen_o;
		end
	end

	// ====================
	// Port A drive
	// ====================
	assign a_addr_o   = addr_q;
	assign a_din_o    = (state_q == ST_FILL) ? rom_din : din_q;
	assign rd_entry_o = a_dout_i[way_q];

	always_comb begin
		a_we_o = we_q;
		case (state_q)
			ST_FILL:     a_we_o[ROM_WAY] = 1'b1;
			ST_SWEEP_WR: a_we_o = stale;
			default: ;
		endcase
	end

	// ====================
	// FSM
	// ====================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state_q      <= ST_FILL;
			addr_q       <= '0;
			we_q         <= '0;
			rd_done_o    <= 1'b0;
			master_gen_o <= GEN_W'(1);
		end else begin
			we_q      <= '0;
			rd_done_o <= 1'b0;
			case (state_q)
				ST_FILL: begin
					addr_q <= addr_q + 1'b1;
					if (addr_q == IDX_BITS'(IDX_ENTRIES - 1)) begin
						state_q <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (accept) begin
						case (cmd_i.op)
							CMD_WRITE: begin
								we_q   <= NUM_WAYS'(1) << cmd_i.way;
								addr_q <= cmd_i.index;
							end
							CMD_READ: begin
								addr_q  <= cmd_i.index;
								state_q <= ST_RDWAIT;
							end
							CMD_INVALL: begin
								master_gen_o <= gen_next;
								addr_q       <= '0;
								state_q      <= ST_SWEEP_RD;
							end
							default: ;
						endcase
					end
				end
				// RAM data lands at this edge
				ST_RDWAIT: begin
					rd_done_o <= 1'b1;
					state_q   <= ST_RUN;
				end
				ST_SWEEP_RD: state_q <= ST_SWEEP_WR;
				ST_SWEEP_WR: begin
					addr_q <= addr_q + 1'b1;
					if (addr_q == IDX_BITS'(IDX_ENTRIES - 1)) begin
						state_q <= ST_RUN;
					end else begin
						state_q <= ST_SWEEP_RD;
					end
				end
				default: state_q <= ST_RUN;
			endcase
		end
	end

	// Command payload
	always_ff @(posedge clk_g) begin
		if (accept) begin
			case (cmd_i.op)
				CMD_WRITE: begin
					din_q     <= cmd_i.entry;
					din_q.gen <= master_gen_o;
				end
				CMD_READ:   way_q <= cmd_i.way;
				// Cleared entry for the sweep, valid low
				CMD_INVALL: din_q <= '0;
				default: ;
			endcase
		end
	end

endmodule

//--- design/stlb_regs.sv
/*
 * Software register file of the TLB.
 * CTRL holds index in [IDX_BITS-1:0] and way just above it; reads of CTRL
 * also return the missing ASID in the top byte. A CMD write sends one
 * maint command pulse on the next cycle. Read data follows a cs read by
 * one clock.
 */
module stlb_regs (
	input  logic                               rst_i,
	input  logic                               clk_g,
	input  stlb_types_pkg::reg_req_t           reg_req_i,
	output logic [stlb_cfg_pkg::DATA_W-1:0]    reg_rdata_o,
	output stlb_types_pkg::maint_cmd_t         cmd_o,
	input  stlb_types_pkg::tlb_entry_t         rd_entry_i,
	input  logic                               rd_done_i,
	input  stlb_types_pkg::xlat_resp_t         xlat_resp_i,
	output logic                               miss_irq_o
);
	import stlb_cfg_pkg::*;
	import stlb_types_pkg::*;

	pte_t                pte_q;
	vpn_tag_t            vpn_q;
	logic [IDX_BITS-1:0] idx_q;
	logic [WAY_BITS-1:0] way_q;
	logic [ADDR_W-1:0]   miss_vadr_q;
	logic [ASID_W-1:0]   miss_asid_q;
	logic [DATA_W-1:0]   rd_mux;
	logic                wr_en;
	logic                rd_en;

	assign wr_en = reg_req_i.cs & reg_req_i.we;
	assign rd_en = reg_req_i.cs & ~reg_req_i.we;

	// Interrupt lines up with the missing response
	assign miss_irq_o = xlat_resp_i.valid & ~xlat_resp_i.hit;

	// ====================
	// Writes and read-back
	// ====================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			pte_q <= '0;
			vpn_q <= '0;
			idx_q <= '0;
			way_q <= '0;
		end else begin
			if (wr_en) begin
				case (reg_req_i.addr)
					REG_PTE:  pte_q <= pte_t'(reg_req_i.wdata[$bits(pte_t)-1:0]);
					REG_VPN:  vpn_q <= vpn_tag_t'(reg_req_i.wdata[$bits(vpn_tag_t)-1:0]);
					REG_CTRL: begin
						idx_q <= reg_req_i.wdata[IDX_BITS-1:0];
						way_q <= reg_req_i.wdata[IDX_BITS +: WAY_BITS];
					end
					default: ;
				endcase
			end
			// Entry read completes into PTE/VPN
			if (rd_done_i) begin
				pte_q <= rd_entry_i.pte;
				vpn_q <= rd_entry_i.tag;
			end
		end
	end

	// Command pulse, one cycle wide
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			cmd_o <= '0;
		end else begin
			cmd_o.op <= CMD_NONE;
			if (wr_en && reg_req_i.addr == REG_CMD) begin
				cmd_o.op        <= cmd_e'(reg_req_i.wdata[1:0]);
				cmd_o.index     <= idx_q;
				cmd_o.way       <= way_q;
				cmd_o.entry.gen <= '0;
				cmd_o.entry.tag <= vpn_q;
				cmd_o.entry.pte <= pte_q;
			end
		end
	end

	// Miss capture
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			miss_vadr_q <= '0;
			miss_asid_q <= '0;
		end else if (miss_irq_o) begin
			miss_vadr_q <= xlat_resp_i.vadr;
			miss_asid_q <= xlat_resp_i.asid;
		end
	end

	// ====================
	// Read data
	// ====================
	always_comb begin
		rd_mux = '0;
		case (reg_req_i.addr)
			REG_PTE:  rd_mux[$bits(pte_t)-1:0] = pte_q;
			REG_VPN:  rd_mux[$bits(vpn_tag_t)-1:0] = vpn_q;
			REG_MISS: rd_mux[ADDR_W-1:0] = miss_vadr_q;
			REG_CTRL: begin
				rd_mux[IDX_BITS-1:0] = idx_q;
				rd_mux[IDX_BITS +: WAY_BITS] = way_q;
				rd_mux[DATA_W-1 -: ASID_W] = miss_asid_q;
			end
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			reg_rdata_o <= '0;
		end else if (rd_en) begin
			reg_rdata_o <= rd_mux;
		end else begin
			reg_rdata_o <= '0;
		end
	end

endmodule

//--- design/stlb_top.sv
/*
 * Shared TLB top level. Connects the register file, maintenance FSM,
 * lookup pipeline and NUM_WAYS dual-port way RAMs.
 */
module stlb_top (
	input  logic                               rst_i,
	input  logic                               clk_g,
	input  stlb_types_pkg::xlat_req_t          xlat_req_i,
	output stlb_types_pkg::xlat_resp_t         xlat_resp_o,
	output logic                               miss_irq_o,
	output logic                               rdy_o,
	input  stlb_types_pkg::reg_req_t           reg_req_i,
	output logic [stlb_cfg_pkg::DATA_W-1:0]    reg_rdata_o
);
	import stlb_cfg_pkg::*;
	import stlb_types_pkg::*;

	maint_cmd_t                 cmd;
	tlb_entry_t                 rd_entry;
	logic                       rd_done;
	logic [GEN_W-1:0]           master_gen;
	logic [IDX_BITS-1:0]        a_addr;
	logic [IDX_BITS-1:0]        b_addr;
	logic [NUM_WAYS-1:0]        a_we;
	tlb_entry_t                 a_din;
	tlb_entry_t [NUM_WAYS-1:0]  a_dout;
	tlb_entry_t [NUM_WAYS-1:0]  b_dout;

	stlb_regs u_regs (
		.rst_i       (rst_i),
		.clk_g       (clk_g),
		.reg_req_i   (reg_req_i),
		.reg_rdata_o (reg_rdata_o),
		.cmd_o       (cmd),
		.rd_entry_i  (rd_entry),
		.rd_done_i   (rd_done),
		.xlat_resp_i (xlat_resp_o),
		.miss_irq_o  (miss_irq_o)
	);

	stlb_maint u_maint (
		.rst_i        (rst_i),
		.clk_g        (clk_g),
		.cmd_i        (cmd),
		.rdy_o        (rdy_o),
		.master_gen_o (master_gen),
		.rd_entry_o   (rd_entry),
		.rd_done_o    (rd_done),
		.a_addr_o     (a_addr),
		.a_we_o       (a_we),
		.a_din_o      (a_din),
		.a_dout_i     (a_dout)
	);

	stlb_lookup u_lookup (
		.rst_i        (rst_i),
		.clk_g        (clk_g),
		.xlat_req_i   (xlat_req_i),
		.master_gen_i (master_gen),
		.b_addr_o     (b_addr),
		.b_dout_i     (b_dout),
		.xlat_resp_o  (xlat_resp_o)
	);

	// Ways share port A address and data
	for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
		stlb_way_ram u_way (
			.clk_g    (clk_g),
			.a_addr_i (a_addr),
			.a_we_i   (a_we[g]),
			.a_din_i  (a_din),
			.a_dout_o (a_dout[g]),
			.b_addr_i (b_addr),
			.b_dout_o (b_dout[g])
		);
	end

endmodule

//--- design/stlb_types_pkg.sv
/*
 * Packed structs and enums shared by the TLB blocks and the testbench.
 * Entry layout is what each way RAM stores. PTE and VPN register images
 * on the register port are pte_t and vpn_tag_t, zero extended.
 */
package stlb_types_pkg;
	import stlb_cfg_pkg::*;

	// ====================
	// Enums
	// ====================
	typedef enum logic [2:0] {
		REG_PTE  = 3'd0,
		REG_VPN  = 3'd1,
		REG_MISS = 3'd2,
		REG_CTRL = 3'd3,
		REG_CMD  = 3'd4
	} reg_addr_e;

	// CMD register write data bits [1:0]
	typedef enum logic [1:0] {
		CMD_NONE   = 2'd0,
		CMD_WRITE  = 2'd1,
		CMD_READ   = 2'd2,
		CMD_INVALL = 2'd3
	} cmd_e;

	typedef enum logic [2:0] {
		ST_FILL,
		ST_RUN,
		ST_RDWAIT,
		ST_SWEEP_RD,
		ST_SWEEP_WR
	} maint_state_e;

	// ====================
	// Entry
	// ====================
	typedef struct packed {
		logic             valid;
		logic             glob;
		logic [2:0]       rwx;
		logic [VPN_W-1:0] ppn;
	} pte_t;

	typedef struct packed {
		logic [ASID_W-1:0] asid;
		logic [VPN_W-1:0]  vpn;
	} vpn_tag_t;

	typedef struct packed {
		logic [GEN_W-1:0] gen;
		vpn_tag_t         tag;
		pte_t             pte;
	} tlb_entry_t;

	// ====================
	// Ports
	// ====================
	typedef struct packed {
		logic              valid;
		logic [ASID_W-1:0] asid;
		logic [ADDR_W-1:0] vadr;
	} xlat_req_t;

	typedef struct packed {
		logic              valid;
		logic              hit;
		logic [2:0]        rwx;
		logic [ADDR_W-1:0] padr;
		logic [ADDR_W-1:0] vadr;
		logic [ASID_W-1:0] asid;
	} xlat_resp_t;

	typedef struct packed {
		logic              cs;
		logic              we;
		reg_addr_e         addr;
		logic [DATA_W-1:0] wdata;
	} reg_req_t;

	// Entry gen is filled in by maintenance
	typedef struct packed {
		cmd_e                op;
		logic [IDX_BITS-1:0] index;
		logic [WAY_BITS-1:0] way;
		tlb_entry_t          entry;
	} maint_cmd_t;

endpackage

//--- design/stlb_way_ram.sv
/*
 * One TLB way. Port A is the maintenance read/write port, port B the
 * read-only lookup port. Both reads are registered, so data appears
 * the cycle after the address, as in a block RAM.
 */
module stlb_way_ram (
	input  logic                                clk_g,
	input  logic [stlb_cfg_pkg::IDX_BITS-1:0]   a_addr_i,
	input  logic                                a_we_i,
	input  stlb_types_pkg::tlb_entry_t          a_din_i,
	output stlb_types_pkg::tlb_entry_t          a_dout_o,
	input  logic [stlb_cfg_pkg::IDX_BITS-1:0]   b_addr_i,
	output stlb_types_pkg::tlb_entry_t          b_dout_o
);
	import stlb_cfg_pkg::*;
	import stlb_types_pkg::*;

	tlb_entry_t mem [IDX_ENTRIES];

	// Port A, old data on a write cycle
	always_ff @(posedge clk_g) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_din_i;
		end
		a_dout_o <= mem[a_addr_i];
	end

	// Port B
	always_ff @(posedge clk_g) begin
		b_dout_o <= mem[b_addr_i];
	end

endmodule

//--- include/stlb_tb_model.svh
/*
 * Reference model of the TLB for the testbench.
 * Include inside the testbench module after importing both packages.
 * Mirror every write, invalidate and reset with the model functions,
 * then call model_lookup for the expected result of a request.
 */
`ifndef STLB_TB_MODEL_SVH
`define STLB_TB_MODEL_SVH

tlb_entry_t       shadow [NUM_WAYS][IDX_ENTRIES];
logic [GEN_W-1:0] shadow_gen;

// Identity fill of the top pages into the last way
function automatic void model_reset();
	shadow_gen = GEN_W'(1);
	for (int w = 0; w < NUM_WAYS; w++) begin
		for (int i = 0; i < IDX_ENTRIES; i++) begin
			shadow[w][i] = '0;
		end
	end
	for (int i = 0; i < IDX_ENTRIES; i++) begin
		shadow[ROM_WAY][i].gen = shadow_gen;
		shadow[ROM_WAY][i].tag.vpn = ROM_VPN_BASE | VPN_W'(i);
		shadow[ROM_WAY][i].pte = '{valid: 1'b1, glob: 1'b1, rwx: ROM_RWX,
			ppn: ROM_VPN_BASE | VPN_W'(i)};
	end
endfunction

function automatic void model_write(input int way, input int idx, input vpn_tag_t tag,
	input pte_t pte);
	shadow[way][idx].gen = shadow_gen;
	shadow[way][idx].tag = tag;
	shadow[way][idx].pte = pte;
endfunction

// Stale entries become all zero
function automatic void model_invall();
	shadow_gen = (shadow_gen == '1) ? GEN_W'(1) : shadow_gen + 1'b1;
	for (int w = 0; w < NUM_WAYS; w++) begin
		for (int i = 0; i < IDX_ENTRIES; i++) begin
			if (shadow[w][i].gen != shadow_gen) begin
				shadow[w][i] = '0;
			end
		end
	end
endfunction

function automatic void model_lookup(input logic [ASID_W-1:0] asid,
	input logic [ADDR_W-1:0] vadr, output logic hit, output logic [ADDR_W-1:0] padr,
	output logic [2:0] rwx);
	tlb_entry_t e;
	int idx;
	hit = 1'b0;
	padr = vadr;
	rwx = '0;
	idx = int'(vadr[PAGE_BITS +: IDX_BITS]);
	for (int w = 0; w < NUM_WAYS; w++) begin
		e = shadow[w][idx];
		if (!hit && e.gen == shadow_gen && e.pte.valid &&
			(e.tag.asid == asid || e.pte.glob) && e.tag.vpn == vadr[ADDR_W-1:PAGE_BITS]) begin
			hit = 1'b1;
			padr = {e.pte.ppn, vadr[PAGE_BITS-1:0]};
			rwx = e.pte.rwx;
		end
	end
endfunction

`endif

//--- dv/stlb_tb.sv
/*
 * Testbench for the shared TLB.
 * Drives lookups and register commands on the falling clock edge and
 * mirrors every change in the shadow model. Each lookup response is
 * compared two cycles after its request. Ends with one count line.
 */
module stlb_tb;
	import stlb_cfg_pkg::*;
	import stlb_types_pkg::*;

	`include "stlb_tb_model.svh"

	localparam int CLK_PERIOD = 4;
	// Upper bound on lookups, writes, reads and invalidates in the run
	localparam int NUM_OPS    = 400;
	// Invalidate sweep is the longest maintenance step
	localparam int MAX_LAT    = 2 * IDX_ENTRIES + 8;

	typedef struct packed {
		logic [31:0]       cyc;
		logic [ASID_W-1:0] asid;
		logic [ADDR_W-1:0] vadr;
		logic              hit;
		logic [2:0]        rwx;
		logic [ADDR_W-1:0] padr;
	} exp_resp_t;

	logic              rst_i;
	logic              clk_g;
	xlat_req_t         xlat_req;
	xlat_resp_t        xlat_resp;
	logic              miss_irq;
	logic              rdy;
	reg_req_t          reg_req;
	logic [DATA_W-1:0] reg_rdata;

	exp_resp_t         exp_q [$];
	vpn_tag_t          tag_list [$];
	int                slot_list [$];
	logic [31:0]       cyc;
	logic [ADDR_W-1:0] last_miss_vadr;
	logic [ASID_W-1:0] last_miss_asid;
	int                errors;
	int                checks;
	integer            seed;

	stlb_top dut (
		.rst_i       (rst_i),
		.clk_g       (clk_g),
		.xlat_req_i  (xlat_req),
		.xlat_resp_o (xlat_resp),
		.miss_irq_o  (miss_irq),
		.rdy_o       (rdy),
		.reg_req_i   (reg_req),
		.reg_rdata_o (reg_rdata)
	);

	initial clk_g = 1'b0;
	always #(CLK_PERIOD / 2) clk_g = ~clk_g;

	always @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			cyc <= '0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// ====================
	// Register port
	// ====================
	task automatic reg_write(input reg_addr_e addr, input logic [DATA_W-1:0] data);
		reg_req.cs = 1'b1;
		reg_req.we = 1'b1;
		reg_req.addr = addr;
		reg_req.wdata = data;
		@(negedge clk_g);
		reg_req.cs = 1'b0;
		reg_req.we = 1'b0;
	endtask

	task automatic reg_read(input reg_addr_e addr, output logic [DATA_W-1:0] data);
		reg_req.cs = 1'b1;
		reg_req.we = 1'b0;
		reg_req.addr = addr;
		@(negedge clk_g);
		reg_req.cs = 1'b0;
		data = reg_rdata;
	endtask

	task automatic check_reg(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic wait_ready();
		while (!rdy) begin
			@(negedge clk_g);
		end
	endtask

	task automatic run_cmd(input cmd_e op, input int way, input int idx);
		logic [DATA_W-1:0] ctrl;
		wait_ready();
		ctrl = '0;
		ctrl[IDX_BITS-1:0] = idx[IDX_BITS-1:0];
		ctrl[IDX_BITS +: WAY_BITS] = way[WAY_BITS-1:0];
		reg_write(REG_CTRL, ctrl);
		reg_write(REG_CMD, DATA_W'(op));
		// rdy_o is low here while the command is pending
		wait_ready();
	endtask

	task automatic invalidate_all();
		run_cmd(CMD_INVALL, 0, 0);
		model_invall();
	endtask

	// Random entries; VPN low bits follow the index so the entry can hit
	task automatic write_random_entries(input int count);
		logic [31:0] r;
		vpn_tag_t    tag;
		pte_t        pte;
		int          way;
		int          idx;
		for (int n = 0; n < count; n++) begin
			r = $random(seed);
			way = int'(r[WAY_BITS-1:0]);
			idx = int'(r[WAY_BITS +: IDX_BITS]);
			tag.asid = ASID_W'(r[WAY_BITS+IDX_BITS +: 2]);
			pte.valid = (r[31:29] != 3'd0);
			pte.glob = (r[28:27] == 2'd0);
			pte.rwx = r[26:24];
			r = $random(seed);
			tag.vpn = VPN_W'(r);
			tag.vpn[IDX_BITS-1:0] = idx[IDX_BITS-1:0];
			r = $random(seed);
			pte.ppn = VPN_W'(r);
			wait_ready();
			reg_write(REG_PTE, DATA_W'(pte));
			reg_write(REG_VPN, DATA_W'(tag));
			run_cmd(CMD_WRITE, way, idx);
			model_write(way, idx, tag, pte);
			tag_list.push_back(tag);
			slot_list.push_back(way * IDX_ENTRIES + idx);
		end
	endtask

	// ====================
	// Lookup port
	// ====================
	function automatic logic [ADDR_W-1:0] rand_vadr(input logic [VPN_W-1:0] vpn);
		logic [31:0] r;
		r = $random(seed);
		return {vpn, r[PAGE_BITS-1:0]};
	endfunction

	task automatic issue_lookup(input logic [ASID_W-1:0] asid, input logic [ADDR_W-1:0] vadr);
		exp_resp_t e;
		e.cyc = cyc;
		e.asid = asid;
		e.vadr = vadr;
		model_lookup(asid, vadr, e.hit, e.padr, e.rwx);
		exp_q.push_back(e);
		xlat_req.valid = 1'b1;
		xlat_req.asid = asid;
		xlat_req.vadr = vadr;
		@(negedge clk_g);
	endtask

	task automatic end_lookups();
		xlat_req.valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk_g);
		end
	endtask

	// Own ASID, then a neighbour ASID, back to back
	task automatic lookup_tags();
		foreach (tag_list[i]) begin
			issue_lookup(tag_list[i].asid, rand_vadr(tag_list[i].vpn));
			issue_lookup(tag_list[i].asid ^ ASID_W'(1), rand_vadr(tag_list[i].vpn));
		end
		end_lookups();
	endtask

	task automatic lookup_rom();
		logic [31:0] r;
		for (int i = 0; i < IDX_ENTRIES; i++) begin
			r = $random(seed);
			issue_lookup(r[ASID_W-1:0], rand_vadr(ROM_VPN_BASE | VPN_W'(i)));
		end
		end_lookups();
	endtask

	task automatic lookup_random(input int count);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			issue_lookup(r[ASID_W-1:0], $random(seed));
		end
		end_lookups();
	endtask

	// ====================
	// Response checker
	// ====================
	always @(negedge clk_g) begin
		exp_resp_t e;
		if (exp_q.size() != 0 && exp_q[0].cyc + 2 == cyc) begin
			e = exp_q.pop_front();
			checks++;
			assert (xlat_resp.valid) else begin
				errors++;
				$display("No response two cycles after the lookup of vadr %h", e.vadr);
			end
			assert (xlat_resp.hit === e.hit) else begin
				errors++;
				$display("Error: xlat_resp_o.hit got %h expected %h (vadr %h asid %h)",
					xlat_resp.hit, e.hit, e.vadr, e.asid);
			end
			assert (xlat_resp.padr === e.padr) else begin
				errors++;
				$display("Error: xlat_resp_o.padr got %h expected %h", xlat_resp.padr, e.padr);
			end
			assert (xlat_resp.rwx === e.rwx) else begin
				errors++;
				$display("Error: xlat_resp_o.rwx got %h expected %h", xlat_resp.rwx, e.rwx);
			end
			assert (xlat_resp.vadr === e.vadr) else begin
				errors++;
				$display("Error: xlat_resp_o.vadr got %h expected %h", xlat_resp.vadr, e.vadr);
			end
			assert (xlat_resp.asid === e.asid) else begin
				errors++;
				$display("Error: xlat_resp_o.asid got %h expected %h", xlat_resp.asid, e.asid);
			end
			assert (miss_irq === !e.hit) else begin
				errors++;
				$display("Error: miss_irq_o got %h expected %h", miss_irq, !e.hit);
			end
			if (!e.hit) begin
				last_miss_vadr = e.vadr;
				last_miss_asid = e.asid;
			end
		end else begin
			assert (!xlat_resp.valid) else begin
				errors++;
				$display("Lookup response arrived with no request outstanding");
			end
			assert (!miss_irq) else begin
				errors++;
				$display("Error: miss_irq_o got %h expected %h", miss_irq, 1'b0);
			end
		end
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [DATA_W-1:0] rdata;
		int                slot;
		seed = 39;
		errors = 0;
		checks = 0;
		last_miss_vadr = '0;
		last_miss_asid = '0;
		rst_i = 1'b1;
		xlat_req = '0;
		reg_req = '0;
		model_reset();
		repeat (5) @(posedge clk_g);
		@(negedge clk_g);
		rst_i = 1'b0;
		wait_ready();

		// Reset map, then addresses outside it
		lookup_rom();
		lookup_random(8);

		write_random_entries(24);
		lookup_tags();

		for (int i = 0; i < 4; i++) begin
			slot = slot_list[i];
			run_cmd(CMD_READ, slot / IDX_ENTRIES, slot % IDX_ENTRIES);
			reg_read(REG_PTE, rdata);
			check_reg("reg_rdata_o (PTE)", rdata,
				DATA_W'(shadow[slot / IDX_ENTRIES][slot % IDX_ENTRIES].pte));
			reg_read(REG_VPN, rdata);
			check_reg("reg_rdata_o (VPN)", rdata,
				DATA_W'(shadow[slot / IDX_ENTRIES][slot % IDX_ENTRIES].tag));
		end

		lookup_random(4);
		// Miss capture lands one clock after the last response
		@(negedge clk_g);
		reg_read(REG_MISS, rdata);
		check_reg("reg_rdata_o (MISS)", rdata, DATA_W'(last_miss_vadr));
		reg_read(REG_CTRL, rdata);
		check_reg("reg_rdata_o (CTRL asid)", DATA_W'(rdata[DATA_W-1 -: ASID_W]),
			DATA_W'(last_miss_asid));

		// Everything written so far must miss
		invalidate_all();
		lookup_rom();
		lookup_tags();

		tag_list.delete();
		write_random_entries(8);
		lookup_tags();

		// Run the generation through its wrap back to the same value
		for (int i = 0; i < GEN_W'('1); i++) begin
			invalidate_all();
		end
		lookup_tags();
		lookup_rom();

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(NUM_OPS * MAX_LAT * CLK_PERIOD);
		$display("Timeout: the run did not finish, %0d errors so far", errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the shared TLB testbench with Verilator.
# Exit status is non-zero on a build error, a crash or a failing test.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f stlb.f --top-module stlb_tb -o stlb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/stlb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi
exit 0

//--- stlb.f
+incdir+include
design/stlb_cfg_pkg.sv
design/stlb_types_pkg.sv
design/stlb_way_ram.sv
design/stlb_regs.sv
design/stlb_maint.sv
design/stlb_lookup.sv
design/stlb_top.sv
dv/stlb_tb.sv
